/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the peripheral harness testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_ext_periph_top -f sim.f

./obj_dir/Vtb_ext_periph_top 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

/* sim.f */
verilog/harness_pkg.sv
verilog/reg_bus_if.sv
verilog/periph_decode.sv
verilog/power_ctrl_regs.sv
verilog/power_switch_emu.sv
verilog/slow_memory.sv
verilog/gpio_cnt.sv
verilog/ext_periph_top.sv
tests/tb_ext_periph_top.sv

/* tests/tb_ext_periph_top.sv */
// --------------------
// Testbench for the external peripheral harness
// --------------------

`timescale 1ns/1ns
`default_nettype none

module tb_ext_periph_top;

  localparam int NUM_DOMAINS        = 3;
  localparam int SWITCH_ACK_LATENCY = 15;
  localparam int MEM_WORDS          = 1024;
  localparam int MEM_LATENCY        = 2;
  localparam int ACK_DELAY          = SWITCH_ACK_LATENCY + 1;
  localparam int NUM_MEM_ADDRS      = 8;

  localparam harness_pkg::addr_t PWR_CTRL =
    harness_pkg::POWER_BASE + 32'(harness_pkg::REG_CTRL_OFFSET);
  localparam harness_pkg::addr_t PWR_STATUS =
    harness_pkg::POWER_BASE + 32'(harness_pkg::REG_STATUS_OFFSET);
  localparam harness_pkg::addr_t GPIO_CTRL =
    harness_pkg::GPIO_CNT_BASE + 32'(harness_pkg::REG_CTRL_OFFSET);
  localparam harness_pkg::addr_t GPIO_STATUS =
    harness_pkg::GPIO_CNT_BASE + 32'(harness_pkg::REG_STATUS_OFFSET);

  logic                   clk = 1'b0;
  logic                   arst_n;
  logic                   reg_valid;
  logic                   reg_write;
  harness_pkg::addr_t     reg_addr;
  harness_pkg::data_t     reg_wdata;
  harness_pkg::data_t     reg_rdata;
  logic                   reg_error;
  logic                   reg_ready;
  logic                   mem_req;
  logic                   mem_we;
  harness_pkg::be_t       mem_be;
  harness_pkg::addr_t     mem_addr;
  harness_pkg::data_t     mem_wdata;
  logic                   mem_gnt;
  logic                   mem_rvalid;
  harness_pkg::data_t     mem_rdata;
  logic                   gpio;
  logic                   intr;
  logic [NUM_DOMAINS-1:0] switch_n;
  logic [NUM_DOMAINS-1:0] switch_ack_n;

  // --------------------
  // Reference models
  // --------------------

  logic [31:0]        rand_state = 32'h61241a1f;
  int                 value_errors = 0;
  int                 other_errors = 0;
  harness_pkg::data_t mem_model [MEM_WORDS];
  harness_pkg::data_t rd_word_exp;
  int                 rd_issued = 0;
  int                 rd_returned;
  logic               rd_check;
  harness_pkg::data_t rd_exp;
  logic [NUM_DOMAINS-1:0] pwr_exp;
  harness_pkg::data_t thr_exp;
  logic               intr_check;
  int                 intr_exp;
  int                 intr_count;
  logic [ACK_DELAY-1:0][NUM_DOMAINS-1:0] ack_hist;
  logic [MEM_LATENCY-1:0]                rd_v_pipe;
  logic [MEM_LATENCY-1:0][31:0]          rd_d_pipe;

  always #10 clk = ~clk;

  ext_periph_top #(
    .NUM_DOMAINS        (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY),
    .MEM_WORDS          (MEM_WORDS),
    .MEM_LATENCY        (MEM_LATENCY)
  ) i_ext_periph_top (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .reg_valid_i    (reg_valid),
    .reg_write_i    (reg_write),
    .reg_addr_i     (reg_addr),
    .reg_wdata_i    (reg_wdata),
    .reg_rdata_o    (reg_rdata),
    .reg_error_o    (reg_error),
    .reg_ready_o    (reg_ready),
    .mem_req_i      (mem_req),
    .mem_we_i       (mem_we),
    .mem_be_i       (mem_be),
    .mem_addr_i     (mem_addr),
    .mem_wdata_i    (mem_wdata),
    .mem_gnt_o      (mem_gnt),
    .mem_rvalid_o   (mem_rvalid),
    .mem_rdata_o    (mem_rdata),
    .gpio_i         (gpio),
    .intr_o         (intr),
    .switch_n_o     (switch_n),
    .switch_ack_n_o (switch_ack_n)
  );

  // Acknowledge delay and read latency as fixed delay lines
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_hist    <= '0;
      rd_v_pipe   <= '0;
      rd_d_pipe   <= '0;
      rd_returned <= 0;
      intr_count  <= 0;
    end else begin
      ack_hist[0]  <= pwr_exp;
      rd_v_pipe[0] <= mem_req & ~mem_we;
      rd_d_pipe[0] <= rd_word_exp;
      for (int i = 1; i < ACK_DELAY; i++) begin
        ack_hist[i] <= ack_hist[i-1];
      end
      for (int i = 1; i < MEM_LATENCY; i++) begin
        rd_v_pipe[i] <= rd_v_pipe[i-1];
        rd_d_pipe[i] <= rd_d_pipe[i-1];
      end
      if (mem_rvalid) begin
        rd_returned <= rd_returned + 1;
      end
      if (intr) begin
        intr_count <= intr_count + 1;
      end
    end
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic harness_pkg::data_t merge_bytes(input harness_pkg::data_t old_word,
                                                     input harness_pkg::data_t new_word,
                                                     input harness_pkg::be_t be);
    harness_pkg::data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // Only the two register offsets inside the two windows are mapped
  function automatic logic expect_error(input harness_pkg::addr_t addr);
    logic mapped;
    mapped = (addr < harness_pkg::GPIO_CNT_BASE + harness_pkg::WINDOW_SIZE) &&
             (addr[7:0] == harness_pkg::REG_CTRL_OFFSET ||
              addr[7:0] == harness_pkg::REG_STATUS_OFFSET);
    return !mapped;
  endfunction

  function automatic harness_pkg::addr_t word_addr(input int idx);
    return harness_pkg::addr_t'(idx) << 2;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    value_errors++;
    $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
  endtask

  task automatic report_timeout(input string what);
    other_errors++;
    $display("Timeout at %0t ns while waiting for %s", $time, what);
  endtask

  // --------------------
  // Bus tasks
  // --------------------

  task automatic reg_write_word(input harness_pkg::addr_t addr, input harness_pkg::data_t data);
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_write <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_valid <= 1'b0;
    reg_write <= 1'b0;
    if (addr == PWR_CTRL) begin
      pwr_exp <= data[NUM_DOMAINS-1:0];
    end
    if (addr == GPIO_CTRL) begin
      thr_exp <= data;
    end
  endtask

  task automatic reg_read_check(input harness_pkg::addr_t addr, input harness_pkg::data_t want);
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_write <= 1'b0;
    reg_addr  <= addr;
    rd_check  <= 1'b1;
    rd_exp    <= want;
    @(posedge clk);
    reg_valid <= 1'b0;
    rd_check  <= 1'b0;
  endtask

  task automatic mem_write_word(input int idx, input harness_pkg::data_t data,
                                input harness_pkg::be_t be);
    @(posedge clk);
    mem_req   <= 1'b1;
    mem_we    <= 1'b1;
    mem_be    <= be;
    mem_addr  <= word_addr(idx);
    mem_wdata <= data;
    mem_model[idx] = merge_bytes(mem_model[idx], data, be);
  endtask

  task automatic mem_read_word(input int idx);
    @(posedge clk);
    mem_req     <= 1'b1;
    mem_we      <= 1'b0;
    mem_addr    <= word_addr(idx);
    rd_word_exp <= mem_model[idx];
    rd_issued++;
  endtask

  task automatic mem_idle();
    @(posedge clk);
    mem_req <= 1'b0;
    mem_we  <= 1'b0;
  endtask

  task automatic wait_reads_done();
    int t = 0;
    while (rd_returned != rd_issued && t < 20) begin
      @(posedge clk);
      t++;
    end
    if (rd_returned != rd_issued) begin
      report_timeout("memory read data");
    end
  endtask

  task automatic wait_ack(input logic [NUM_DOMAINS-1:0] want);
    int t = 0;
    while (switch_ack_n != want && t < 3 * ACK_DELAY) begin
      @(posedge clk);
      t++;
    end
    if (switch_ack_n != want) begin
      report_timeout("power switch acknowledge");
    end
  endtask

  task automatic gpio_run(input int thr, input int edges);
    reg_write_word(GPIO_CTRL, 32'(thr));
    intr_exp <= intr_count + edges / thr;
    // Slow edges, well above the synchronizer delay
    for (int e = 0; e < edges; e++) begin
      gpio <= 1'b1;
      repeat (4) @(posedge clk);
      gpio <= 1'b0;
      repeat (4) @(posedge clk);
    end
    intr_check <= 1'b1;
    @(posedge clk);
    intr_check <= 1'b0;
    reg_read_check(GPIO_STATUS, 32'(edges % thr));
    reg_read_check(GPIO_CTRL, 32'(thr));
  endtask

  // --------------------
  // Checks
  // --------------------

  a_ready : assert property (@(negedge clk) disable iff (!arst_n) reg_ready == reg_valid)
    else report_mismatch("reg_ready_o", 32'(reg_ready), 32'(reg_valid));

  a_error : assert property (@(negedge clk) disable iff (!arst_n)
    reg_valid |-> reg_error == expect_error(reg_addr))
    else report_mismatch("reg_error_o", 32'(reg_error), 32'(expect_error(reg_addr)));

  a_unmapped_rdata : assert property (@(negedge clk) disable iff (!arst_n)
    reg_valid && reg_addr >= 32'h200 |-> reg_rdata == '0)
    else report_mismatch("reg_rdata_o", reg_rdata, 32'h0);

  a_read_data : assert property (@(negedge clk) disable iff (!arst_n)
    rd_check |-> reg_rdata == rd_exp)
    else report_mismatch("reg_rdata_o", reg_rdata, rd_exp);

  a_switch : assert property (@(negedge clk) disable iff (!arst_n) switch_n == pwr_exp)
    else report_mismatch("switch_n_o", 32'(switch_n), 32'(pwr_exp));

  a_switch_ack : assert property (@(negedge clk) disable iff (!arst_n)
    switch_ack_n == ack_hist[ACK_DELAY-1])
    else report_mismatch("switch_ack_n_o", 32'(switch_ack_n), 32'(ack_hist[ACK_DELAY-1]));

  a_mem_gnt : assert property (@(negedge clk) disable iff (!arst_n) mem_gnt == mem_req)
    else report_mismatch("mem_gnt_o", 32'(mem_gnt), 32'(mem_req));

  a_mem_rvalid : assert property (@(negedge clk) disable iff (!arst_n)
    mem_rvalid == rd_v_pipe[MEM_LATENCY-1])
    else report_mismatch("mem_rvalid_o", 32'(mem_rvalid), 32'(rd_v_pipe[MEM_LATENCY-1]));

  a_mem_rdata : assert property (@(negedge clk) disable iff (!arst_n)
    mem_rvalid |-> mem_rdata == rd_d_pipe[MEM_LATENCY-1])
    else report_mismatch("mem_rdata_o", mem_rdata, rd_d_pipe[MEM_LATENCY-1]);

  // Zero threshold disables counting
  a_intr_idle : assert property (@(negedge clk) disable iff (!arst_n)
    thr_exp == '0 |-> !intr)
    else report_mismatch("intr_o", 32'(intr), 32'h0);

  a_intr_count : assert property (@(negedge clk) disable iff (!arst_n)
    intr_check |-> intr_count == intr_exp)
    else report_mismatch("intr_o pulse count", 32'(intr_count), 32'(intr_exp));

  // --------------------
  // Stimulus
  // --------------------

  initial begin
    harness_pkg::data_t pwr_val;
    harness_pkg::addr_t bad_addr;
    int                 mem_idx [NUM_MEM_ADDRS];
    arst_n      <= 1'b0;
    reg_valid   <= 1'b0;
    reg_write   <= 1'b0;
    reg_addr    <= '0;
    reg_wdata   <= '0;
    mem_req     <= 1'b0;
    mem_we      <= 1'b0;
    mem_be      <= '0;
    mem_addr    <= '0;
    mem_wdata   <= '0;
    gpio        <= 1'b0;
    rd_check    <= 1'b0;
    rd_exp      <= '0;
    rd_word_exp <= '0;
    pwr_exp     <= '0;
    thr_exp     <= '0;
    intr_check  <= 1'b0;
    intr_exp    <= 0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    // Values after reset
    repeat (3) @(posedge clk);
    reg_read_check(PWR_STATUS, '0);
    reg_read_check(GPIO_STATUS, '0);
    reg_read_check(PWR_CTRL, '0);
    reg_read_check(GPIO_CTRL, '0);

    // Full words first, then partial overwrites
    for (int i = 0; i < NUM_MEM_ADDRS; i++) begin
      mem_idx[i] = int'(next_rand() % 32'(MEM_WORDS));
      mem_write_word(mem_idx[i], next_rand(), 4'hF);
    end
    for (int i = 0; i < NUM_MEM_ADDRS; i++) begin
      mem_write_word(mem_idx[i], next_rand(), harness_pkg::be_t'(next_rand()));
    end
    for (int i = 0; i < NUM_MEM_ADDRS; i++) begin
      mem_read_word(mem_idx[i]);
    end
    mem_idle();
    wait_reads_done();
    for (int i = NUM_MEM_ADDRS - 1; i >= 0; i--) begin
      mem_read_word(mem_idx[i]);
      mem_idle();
    end
    wait_reads_done();

    // Power requests
    for (int n = 0; n < 3; n++) begin
      pwr_val = next_rand();
      reg_write_word(PWR_CTRL, pwr_val);
      wait_ack(pwr_val[NUM_DOMAINS-1:0]);
      reg_read_check(PWR_STATUS, 32'(pwr_val[NUM_DOMAINS-1:0]));
      reg_read_check(PWR_CTRL, 32'(pwr_val[NUM_DOMAINS-1:0]));
    end
    reg_write_word(PWR_CTRL, 32'h5);
    reg_write_word(PWR_CTRL, 32'h2);
    reg_write_word(PWR_STATUS, 32'h7);
    wait_ack(3'h2);
    reg_read_check(PWR_STATUS, 32'h2);

    // Unmapped accesses
    reg_read_check(32'h200, '0);
    reg_read_check(32'hFFFF_FFFC, '0);
    for (int n = 0; n < 4; n++) begin
      bad_addr = next_rand() | 32'h200;
      reg_read_check(bad_addr, '0);
      reg_write_word(bad_addr, next_rand());
    end

    gpio_run(3, 7);
    gpio_run(2 + int'(next_rand() % 32'd3), 4 + int'(next_rand() % 32'd6));

    repeat (2) @(posedge clk);
    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/ext_periph_top.sv */
// --------------------
// External peripheral harness top
// --------------------

`timescale 1ns/1ns
`default_nettype none

module ext_periph_top #(
  parameter int NUM_DOMAINS        = 3,
  parameter int SWITCH_ACK_LATENCY = 15,
  parameter int MEM_WORDS          = 1024,
  parameter int MEM_LATENCY        = 2
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  harness_pkg::addr_t     reg_addr_i,
  input  harness_pkg::data_t     reg_wdata_i,
  output harness_pkg::data_t     reg_rdata_o,
  output logic                   reg_error_o,
  output logic                   reg_ready_o,
  input  logic                   mem_req_i,
  input  logic                   mem_we_i,
  input  harness_pkg::be_t       mem_be_i,
  input  harness_pkg::addr_t     mem_addr_i,
  input  harness_pkg::data_t     mem_wdata_i,
  output logic                   mem_gnt_o,
  output logic                   mem_rvalid_o,
  output harness_pkg::data_t     mem_rdata_o,
  input  logic                   gpio_i,
  output logic                   intr_o,
  output logic [NUM_DOMAINS-1:0] switch_n_o,
  output logic [NUM_DOMAINS-1:0] switch_ack_n_o
);

  logic [NUM_DOMAINS-1:0] switch_n;
  logic [NUM_DOMAINS-1:0] switch_ack_n;

  reg_bus_if ext_bus ();
  reg_bus_if power_bus ();
  reg_bus_if gpio_bus ();

  // Plain ports onto the internal bus
  assign ext_bus.valid = reg_valid_i;
  assign ext_bus.write = reg_write_i;
  assign ext_bus.addr  = reg_addr_i;
  assign ext_bus.wdata = reg_wdata_i;
  assign reg_rdata_o   = ext_bus.rdata;
  assign reg_error_o   = ext_bus.error;
  assign reg_ready_o   = ext_bus.ready;

  assign switch_n_o     = switch_n;
  assign switch_ack_n_o = switch_ack_n;

  periph_decode i_periph_decode (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .in_bus    (ext_bus),
    .power_bus (power_bus),
    .gpio_bus  (gpio_bus)
  );

  power_ctrl_regs #(
    .NUM_DOMAINS (NUM_DOMAINS)
  ) i_power_ctrl_regs (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .bus            (power_bus),
    .switch_n_o     (switch_n),
    .switch_ack_n_i (switch_ack_n)
  );

  power_switch_emu #(
    .NUM_DOMAINS        (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY)
  ) i_power_switch_emu (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .switch_n_i     (switch_n),
    .switch_ack_n_o (switch_ack_n)
  );

  slow_memory #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) i_slow_memory (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (mem_req_i),
    .we_i     (mem_we_i),
    .be_i     (mem_be_i),
    .addr_i   (mem_addr_i),
    .wdata_i  (mem_wdata_i),
    .gnt_o    (mem_gnt_o),
    .rvalid_o (mem_rvalid_o),
    .rdata_o  (mem_rdata_o)
  );

  gpio_cnt i_gpio_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus      (gpio_bus),
    .gpio_i   (gpio_i),
    .intr_o   (intr_o)
  );

endmodule

`default_nettype wire

/* verilog/gpio_cnt.sv */
// --------------------
// GPIO edge counter
// Counts rising edges and interrupts at a threshold
// --------------------

`timescale 1ns/1ns
`default_nettype none

module gpio_cnt (
  input  logic      clk_i,
  input  logic      arst_n_i,
  reg_bus_if.device bus,
  input  logic      gpio_i,
  output logic      intr_o
);

  logic               is_ctrl;
  logic               is_status;
  logic               thr_wr;
  logic               rise;
  logic [2:0]         sync_q;
  harness_pkg::data_t thr_q;
  harness_pkg::data_t cnt_q;
  harness_pkg::data_t cnt_next;
  logic               intr_q;

  assign is_ctrl   = bus.addr[7:0] == harness_pkg::REG_CTRL_OFFSET;
  assign is_status = bus.addr[7:0] == harness_pkg::REG_STATUS_OFFSET;
  assign thr_wr    = bus.valid & bus.write & is_ctrl;

  // Two sync flops, the third keeps the previous level
  assign rise     = sync_q[1] & ~sync_q[2];
  assign cnt_next = cnt_q + 32'd1;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
      thr_q  <= '0;
      cnt_q  <= '0;
      intr_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[1:0], gpio_i};
      intr_q <= 1'b0;
      if (thr_wr) begin
        // New threshold restarts the count
        thr_q <= bus.wdata;
        cnt_q <= '0;
      end else if (rise && thr_q != '0) begin
        if (cnt_next == thr_q) begin
          cnt_q  <= '0;
          intr_q <= 1'b1;
        end else begin
          cnt_q <= cnt_next;
        end
      end
    end
  end

  assign intr_o = intr_q;

  always_comb begin
    bus.ready = bus.valid;
    bus.error = bus.valid & ~(is_ctrl | is_status);
    bus.rdata = '0;
    if (is_ctrl) begin
      bus.rdata = thr_q;
    end else if (is_status) begin
      bus.rdata = cnt_q;
    end
  end

  a_intr_pulse : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    intr_o |=> !intr_o
  ) else $error("gpio_cnt: interrupt held for two cycles");

endmodule

`default_nettype wire

/* verilog/harness_pkg.sv */
// --------------------
// Peripheral harness shared definitions
// Bus widths, address map and register offsets
// --------------------

`default_nettype none

package harness_pkg;

  // --------------------
  // Bus types
  // --------------------

  // Byte address on the register bus and the memory bus
  typedef logic [31:0] addr_t;

  typedef logic [31:0] data_t;

  // One enable per byte lane of data_t
  typedef logic [3:0] be_t;

  // --------------------
  // Address map
  // --------------------

  // Register-bus targets behind the demultiplexer
  typedef enum logic [0:0] {
    PERIPH_POWER    = 1'b0,
    PERIPH_GPIO_CNT = 1'b1
  } periph_idx_e;

  localparam int NUM_PERIPHS = 2;

  localparam addr_t POWER_BASE    = 32'h0000_0000;
  localparam addr_t GPIO_CNT_BASE = 32'h0000_0100;

  // Every peripheral owns one window of this size
  localparam addr_t WINDOW_SIZE = 32'h0000_0100;

  // --------------------
  // Register offsets
  // --------------------

  // Writable control register, same offset in every peripheral
  localparam logic [7:0] REG_CTRL_OFFSET = 8'h00;

  // Read-only status register
  localparam logic [7:0] REG_STATUS_OFFSET = 8'h04;

endpackage

`default_nettype wire

/* verilog/periph_decode.sv */
// --------------------
// Register-bus demultiplexer
// Routes each access to the peripheral whose window holds the address
// --------------------

`timescale 1ns/1ns
`default_nettype none

module periph_decode (
  input  logic          clk_i,
  input  logic          arst_n_i,
  reg_bus_if.device     in_bus,
  reg_bus_if.host       power_bus,
  reg_bus_if.host       gpio_bus
);

  logic [harness_pkg::NUM_PERIPHS-1:0] sel;

  // Wrapping difference also covers a window based at zero
  function automatic logic in_window(input harness_pkg::addr_t addr,
                                     input harness_pkg::addr_t base);
    return (addr - base) < harness_pkg::WINDOW_SIZE;
  endfunction

  always_comb begin
    sel = '0;
    sel[harness_pkg::PERIPH_POWER]    = in_window(in_bus.addr, harness_pkg::POWER_BASE);
    sel[harness_pkg::PERIPH_GPIO_CNT] = in_window(in_bus.addr, harness_pkg::GPIO_CNT_BASE);
  end

  // --------------------
  // Request side
  // --------------------

  assign power_bus.valid = in_bus.valid & sel[harness_pkg::PERIPH_POWER];
  assign power_bus.write = in_bus.write;
  assign power_bus.addr  = in_bus.addr;
  assign power_bus.wdata = in_bus.wdata;

  assign gpio_bus.valid = in_bus.valid & sel[harness_pkg::PERIPH_GPIO_CNT];
  assign gpio_bus.write = in_bus.write;
  assign gpio_bus.addr  = in_bus.addr;
  assign gpio_bus.wdata = in_bus.wdata;

  // --------------------
  // Response side
  // --------------------

  always_comb begin
    in_bus.rdata = '0;
    in_bus.error = 1'b0;
    in_bus.ready = in_bus.valid;
    if (sel[harness_pkg::PERIPH_POWER]) begin
      in_bus.rdata = power_bus.rdata;
      in_bus.error = power_bus.error;
      in_bus.ready = power_bus.ready;
    end else if (sel[harness_pkg::PERIPH_GPIO_CNT]) begin
      in_bus.rdata = gpio_bus.rdata;
      in_bus.error = gpio_bus.error;
      in_bus.ready = gpio_bus.ready;
    end else begin
      // Unmapped, answered here
      in_bus.error = in_bus.valid;
    end
  end

  a_one_target : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({power_bus.valid, gpio_bus.valid})
  ) else $error("periph_decode: more than one peripheral selected");

endmodule

`default_nettype wire

/* verilog/power_ctrl_regs.sv */
// --------------------
// Power-control registers
// Per-domain switch requests and their acknowledges
// --------------------

`timescale 1ns/1ns
`default_nettype none

module power_ctrl_regs #(
  parameter int NUM_DOMAINS = 3
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  reg_bus_if.device              bus,
  output logic [NUM_DOMAINS-1:0] switch_n_o,
  input  logic [NUM_DOMAINS-1:0] switch_ack_n_i
);

  logic                   is_ctrl;
  logic                   is_status;
  logic [NUM_DOMAINS-1:0] switch_q;

  assign is_ctrl   = bus.addr[7:0] == harness_pkg::REG_CTRL_OFFSET;
  assign is_status = bus.addr[7:0] == harness_pkg::REG_STATUS_OFFSET;

  // Active-low requests, so all zero keeps every domain on
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      switch_q <= '0;
    end else if (bus.valid && bus.write && is_ctrl) begin
      switch_q <= bus.wdata[NUM_DOMAINS-1:0];
    end
  end

  assign switch_n_o = switch_q;

  // --------------------
  // Read path
  // --------------------

  always_comb begin
    bus.ready = bus.valid;
    bus.error = bus.valid & ~(is_ctrl | is_status);
    bus.rdata = '0;
    if (is_ctrl) begin
      bus.rdata = harness_pkg::data_t'(switch_q);
    end else if (is_status) begin
      // Writes here fall through silently
      bus.rdata = harness_pkg::data_t'(switch_ack_n_i);
    end
  end

endmodule

`default_nettype wire

/* verilog/power_switch_emu.sv */
// --------------------
// Power-switch emulation
// Returns each request as an acknowledge after a delay line
// --------------------

`timescale 1ns/1ns
`default_nettype none

module power_switch_emu #(
  parameter int NUM_DOMAINS        = 3,
  parameter int SWITCH_ACK_LATENCY = 15
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [NUM_DOMAINS-1:0] switch_n_i,
  output logic [NUM_DOMAINS-1:0] switch_ack_n_o
);

  localparam int STAGES = SWITCH_ACK_LATENCY + 1;

  logic [STAGES-1:0][NUM_DOMAINS-1:0] ack_q;

  // Stage 0 samples the request, the last stage is the acknowledge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= '0;
    end else begin
      ack_q[0] <= switch_n_i;
      for (int i = 1; i < STAGES; i++) begin
        ack_q[i] <= ack_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = ack_q[STAGES-1];

endmodule

`default_nettype wire

/* verilog/reg_bus_if.sv */
// --------------------
// Register bus with same-cycle ready
// --------------------

`timescale 1ns/1ns
`default_nettype none

interface reg_bus_if;

  logic               valid;
  logic               write;
  harness_pkg::addr_t addr;
  harness_pkg::data_t wdata;
  harness_pkg::data_t rdata;
  logic               error;
  logic               ready;

  // Side that starts an access
  modport host (
    output valid, write, addr, wdata,
    input  rdata, error, ready
  );

  // Side that answers an access in the same cycle
  modport device (
    input  valid, write, addr, wdata,
    output rdata, error, ready
  );

endinterface

`default_nettype wire

/* verilog/slow_memory.sv */
// --------------------
// Slow word memory
// Byte-enable writes, reads return after a fixed latency
// --------------------

`timescale 1ns/1ns
`default_nettype none

module slow_memory #(
  parameter int MEM_WORDS   = 1024,
  parameter int MEM_LATENCY = 2
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::be_t   be_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::data_t wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output harness_pkg::data_t rdata_o
);

  localparam int IDX_W   = $clog2(MEM_WORDS);
  localparam int NUM_BES = $bits(harness_pkg::be_t);

  harness_pkg::data_t mem [MEM_WORDS];

  logic [IDX_W-1:0]                          idx;
  logic                                      rd_req;
  logic [MEM_LATENCY-1:0]                    rvalid_q;
  logic [MEM_LATENCY-1:0][$bits(harness_pkg::data_t)-1:0] rdata_q;

  // Word index sits above the two byte bits
  assign idx    = addr_i[IDX_W+1:2];
  assign gnt_o  = req_i;
  assign rd_req = req_i & ~we_i;

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < NUM_BES; b++) begin
        if (be_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // --------------------
  // Read pipeline
  // --------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q[0] <= rd_req;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        rvalid_q[i] <= rvalid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q[0] <= mem[idx];
    for (int i = 1; i < MEM_LATENCY; i++) begin
      rdata_q[i] <= rdata_q[i-1];
    end
  end

  assign rvalid_o = rvalid_q[MEM_LATENCY-1];
  assign rdata_o  = rdata_q[MEM_LATENCY-1];

  a_read_latency : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req_i && gnt_o && !we_i |-> ##MEM_LATENCY rvalid_o
  ) else $error("slow_memory: read data missed its latency");

endmodule

`default_nettype wire
